// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_masked_alu
FILELIST  := masked_alu.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== masked_alu.f ====
masked_data_pkg.sv
masked_op_pkg.sv
masked_operand_if.sv
masked_prng.sv
masked_bool_unit.sv
masked_shift_unit.sv
masked_arith_unit.sv
masked_result_stage.sv
masked_alu_top.sv
tb_masked_alu.sv

// ==== masked_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_alu_top (
  input  wire                            g_clk,
  input  wire                            g_resetn,
  input  wire                            i_valid,
  input  wire                            i_prng_update,
  input  wire masked_op_pkg::masked_op_e i_op,
  input  wire masked_data_pkg::word_t    i_rs1_s0,
  input  wire masked_data_pkg::word_t    i_rs1_s1,
  input  wire masked_data_pkg::word_t    i_rs2_s0,
  input  wire masked_data_pkg::word_t    i_rs2_s1,
  output wire                            o_ready,
  output wire masked_data_pkg::word_t    o_rd_s0,
  output wire masked_data_pkg::word_t    o_rd_s1
);

  masked_data_pkg::word_t       gs0, gs1;
  masked_data_pkg::share_pair_t bool_res, shift_res, arith_res;

  masked_operand_if opnd ();

  // Source side of the operand bundle
  assign opnd.op     = i_op;
  assign opnd.rs1_s0 = i_rs1_s0;
  assign opnd.rs1_s1 = i_rs1_s1;
  assign opnd.rs2_s0 = i_rs2_s0;
  assign opnd.rs2_s1 = i_rs2_s1;

  masked_prng u_prng (.g_clk, .g_resetn, .i_valid, .i_prng_update, .o_gs0(gs0), .o_gs1(gs1));

  masked_bool_unit u_bool (.opnd(opnd), .i_gs0(gs0), .i_gs1(gs1), .o_res(bool_res));

  // One shifter per share, same padding word
  masked_shift_unit u_shift_s0 (.i_share(i_rs1_s0), .i_shamt(i_rs2_s0[masked_data_pkg::SHAMT_W-1:0]),
                                .i_pad(gs0), .i_op(i_op), .o_share(shift_res.s0));
  masked_shift_unit u_shift_s1 (.i_share(i_rs1_s1), .i_shamt(i_rs2_s0[masked_data_pkg::SHAMT_W-1:0]),
                                .i_pad(gs0), .i_op(i_op), .o_share(shift_res.s1));

  masked_arith_unit u_arith (.opnd(opnd), .i_gs(gs0), .o_res(arith_res));

  masked_result_stage u_result (
    .g_clk, .g_resetn, .i_valid, .opnd(opnd),
    .i_bool(bool_res), .i_shift(shift_res), .i_arith(arith_res),
    .o_ready, .o_rd_s0, .o_rd_s1
  );

endmodule

`default_nettype wire

// ==== masked_arith_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_arith_unit (
  masked_operand_if.unit               opnd,
  input  wire masked_data_pkg::word_t  i_gs, // Fresh arithmetic mask
  output masked_data_pkg::share_pair_t o_res
);

  logic                   op_add, op_sub, op_mask, op_remask;
  logic                   carry_in;
  masked_data_pkg::word_t lhs0, rhs0;
  masked_data_pkg::word_t lhs1, rhs1;

  assign op_add    = (opnd.op == masked_op_pkg::OP_A_ADD);
  assign op_sub    = (opnd.op == masked_op_pkg::OP_A_SUB);
  assign op_mask   = (opnd.op == masked_op_pkg::OP_A_MASK);
  assign op_remask = (opnd.op == masked_op_pkg::OP_A_REMASK);

  assign carry_in = op_sub; // Two's complement of rs2, per share

  assign lhs0 = opnd.rs1_s0;
  assign rhs0 = op_add ? opnd.rs2_s0
              : op_sub ? ~opnd.rs2_s0
              :          i_gs;            // Mask and remask

  assign lhs1 = op_mask ? i_gs : opnd.rs1_s1;
  assign rhs1 = op_add    ? opnd.rs2_s1
              : op_sub    ? ~opnd.rs2_s1
              : op_remask ? i_gs
              :             '0;           // Mask keeps share 1 as gs

  // s0 - s1 is preserved modulo 2**XLEN
  assign o_res.s0 = lhs0 + rhs0 + {{(masked_data_pkg::XLEN-1){1'b0}}, carry_in};
  assign o_res.s1 = lhs1 + rhs1 + {{(masked_data_pkg::XLEN-1){1'b0}}, carry_in};

endmodule

`default_nettype wire

// ==== masked_bool_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_bool_unit (
  masked_operand_if.unit               opnd,
  input  wire masked_data_pkg::word_t  i_gs0, // Guard share for AND and refresh
  input  wire masked_data_pkg::word_t  i_gs1, // Guard share for XOR
  output masked_data_pkg::share_pair_t o_res
);

  logic                   ior_op;
  masked_data_pkg::word_t a0, a1, b0, b1;
  masked_data_pkg::word_t and0, and1;
  masked_data_pkg::word_t xor0, xor1;
  masked_data_pkg::word_t fresh0;

  // OR via De Morgan, flip share 1 of both inputs
  assign ior_op = (opnd.op == masked_op_pkg::OP_B_IOR);
  assign a0     = opnd.rs1_s0;
  assign a1     = ior_op ? ~opnd.rs1_s1 : opnd.rs1_s1;
  assign b0     = opnd.rs2_s0;
  assign b1     = ior_op ? ~opnd.rs2_s1 : opnd.rs2_s1;

  // Non-DOM AND, cross terms folded into each share with the guard
  assign and0 = i_gs0 ^ (a0 & b1) ^ (a0 | ~b0);
  assign and1 = i_gs0 ^ (a1 & b1) ^ (a1 | ~b0);

  assign xor0 = i_gs1 ^ a0 ^ b0;
  assign xor1 = i_gs1 ^ a1 ^ b1;

  assign fresh0 = opnd.rs1_s0 ^ i_gs0; // Share 0 for mask, remask and NOT

  always_comb begin
    case (opnd.op)
      masked_op_pkg::OP_B_MASK:   o_res = '{s0: fresh0, s1: i_gs0};
      masked_op_pkg::OP_B_REMASK: o_res = '{s0: fresh0, s1: opnd.rs1_s1 ^ i_gs0};
      masked_op_pkg::OP_B_NOT:    o_res = '{s0: fresh0, s1: ~opnd.rs1_s1 ^ i_gs0};
      masked_op_pkg::OP_B_XOR:    o_res = '{s0: xor0, s1: xor1};
      masked_op_pkg::OP_B_AND:    o_res = '{s0: and0, s1: and1};
      masked_op_pkg::OP_B_IOR:    o_res = '{s0: and0, s1: ~and1}; // Undo the inversion
      default:                    o_res = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== masked_data_pkg.sv ====
`default_nettype none

package masked_data_pkg;

  localparam int unsigned XLEN    = 32; // Share width
  localparam int unsigned SHAMT_W = 5;  // Shift amount, log2(XLEN)

  // LFSR reset values
  localparam logic [XLEN-1:0] PRNG0_SEED = 32'h6789ABCD;
  localparam logic [XLEN-1:0] PRNG1_SEED = 32'h87654321;

  // Feedback taps, XNOR combined
  localparam int unsigned PRNG_TAP_A = 31;
  localparam int unsigned PRNG_TAP_B = 21;
  localparam int unsigned PRNG_TAP_C = 1;
  localparam int unsigned PRNG_TAP_D = 0;

  typedef logic [XLEN-1:0] word_t;

  typedef struct packed {
    word_t s0; // Share 0
    word_t s1; // Share 1
  } share_pair_t;

endpackage

`default_nettype wire

// ==== masked_op_pkg.sv ====
`default_nettype none

package masked_op_pkg;

  typedef enum logic [3:0] {
    OP_B_MASK   = 4'd0,
    OP_B_REMASK = 4'd1,
    OP_B_NOT    = 4'd2,
    OP_B_XOR    = 4'd3,
    OP_B_AND    = 4'd4,
    OP_B_IOR    = 4'd5,
    OP_B_SRLI   = 4'd6,  // Shift amounts come from rs2 share 0
    OP_B_SLLI   = 4'd7,
    OP_B_RORI   = 4'd8,
    OP_A_MASK   = 4'd9,
    OP_A_REMASK = 4'd10,
    OP_A_ADD    = 4'd11,
    OP_A_SUB    = 4'd12
  } masked_op_e;

  function automatic logic is_bool_op(input masked_op_e op);
    return op inside {OP_B_MASK, OP_B_REMASK, OP_B_NOT, OP_B_XOR, OP_B_AND, OP_B_IOR};
  endfunction

  function automatic logic is_shift_op(input masked_op_e op);
    return op inside {OP_B_SRLI, OP_B_SLLI, OP_B_RORI};
  endfunction

  function automatic logic is_arith_op(input masked_op_e op);
    return op inside {OP_A_MASK, OP_A_REMASK, OP_A_ADD, OP_A_SUB};
  endfunction

endpackage

`default_nettype wire

// ==== masked_operand_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface masked_operand_if;

  masked_op_pkg::masked_op_e op;     // Operation of the current request
  masked_data_pkg::word_t    rs1_s0; // First operand, share 0
  masked_data_pkg::word_t    rs1_s1; // First operand, share 1
  masked_data_pkg::word_t    rs2_s0; // Second operand, share 0 (shamt for shifts)
  masked_data_pkg::word_t    rs2_s1; // Second operand, share 1

  modport source (
    output op,
    output rs1_s0,
    output rs1_s1,
    output rs2_s0,
    output rs2_s1
  );

  modport unit (
    input op,
    input rs1_s0,
    input rs1_s1,
    input rs2_s0,
    input rs2_s1
  );

endinterface

`default_nettype wire

// ==== masked_prng.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_prng (
  input  wire                    g_clk,
  input  wire                    g_resetn,
  input  wire                    i_valid,       // Operation accepted
  input  wire                    i_prng_update, // Explicit refresh request
  output masked_data_pkg::word_t o_gs0,
  output masked_data_pkg::word_t o_gs1
);

  masked_data_pkg::word_t prng0_q;
  masked_data_pkg::word_t prng1_q;
  logic                   advance;

  // Shift left, new bit enters at the LSB
  function automatic masked_data_pkg::word_t lfsr_next(input masked_data_pkg::word_t s);
    logic fb;
    fb = ~(s[masked_data_pkg::PRNG_TAP_A] ^ s[masked_data_pkg::PRNG_TAP_B] ^
           s[masked_data_pkg::PRNG_TAP_C] ^ s[masked_data_pkg::PRNG_TAP_D]);
    return {s[masked_data_pkg::XLEN-2:0], fb};
  endfunction

  assign advance = i_valid | i_prng_update;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      prng0_q <= masked_data_pkg::PRNG0_SEED;
      prng1_q <= masked_data_pkg::PRNG1_SEED;
    end else if (advance) begin
      prng0_q <= lfsr_next(prng0_q);
      prng1_q <= lfsr_next(prng1_q);
    end
  end

  assign o_gs0 = prng0_q; // Units see the state before the step
  assign o_gs1 = prng1_q;

endmodule

`default_nettype wire

// ==== masked_result_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_result_stage (
  input  wire                               g_clk,
  input  wire                               g_resetn,
  input  wire                               i_valid,
  masked_operand_if.unit                    opnd,
  input  wire masked_data_pkg::share_pair_t i_bool,
  input  wire masked_data_pkg::share_pair_t i_shift,
  input  wire masked_data_pkg::share_pair_t i_arith,
  output logic                              o_ready,
  output masked_data_pkg::word_t            o_rd_s0,
  output masked_data_pkg::word_t            o_rd_s1
);

  masked_data_pkg::share_pair_t sel;
  masked_data_pkg::share_pair_t rd_q;
  logic                         ready_q;

  // Pick one unit by opcode class
  always_comb begin
    if (masked_op_pkg::is_bool_op(opnd.op)) begin
      sel = i_bool;
    end else if (masked_op_pkg::is_shift_op(opnd.op)) begin
      sel = i_shift;
    end else if (masked_op_pkg::is_arith_op(opnd.op)) begin
      sel = i_arith;
    end else begin
      sel = '0;       // Unused encodings
    end
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      ready_q <= 1'b0;
      rd_q    <= '0;
    end else begin
      ready_q <= i_valid;   // Fixed one-cycle latency
      if (i_valid) begin
        rd_q <= sel;        // Hold until the next accepted op
      end
    end
  end

  assign o_ready = ready_q;
  assign o_rd_s0 = rd_q.s0;
  assign o_rd_s1 = rd_q.s1;

endmodule

`default_nettype wire

// ==== masked_shift_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_shift_unit (
  input  wire masked_data_pkg::word_t                 i_share, // One share of rs1
  input  wire [masked_data_pkg::SHAMT_W-1:0]          i_shamt,
  input  wire masked_data_pkg::word_t                 i_pad,   // Same word on both shares
  input  wire masked_op_pkg::masked_op_e              i_op,
  output masked_data_pkg::word_t                      o_share
);

  logic                   shift_left;
  logic                   rotate;
  masked_data_pkg::word_t lvl [0:masked_data_pkg::SHAMT_W];

  assign shift_left = (i_op == masked_op_pkg::OP_B_SLLI);
  assign rotate     = (i_op == masked_op_pkg::OP_B_RORI); // SRLI takes the plain right path

  assign lvl[0] = i_share;

  // Level k moves by 2**k bits
  for (genvar k = 0; k < masked_data_pkg::SHAMT_W; k++) begin : g_level
    localparam int unsigned N = 1 << k;

    logic [N-1:0]           fill_left;
    logic [N-1:0]           fill_right;
    masked_data_pkg::word_t shl;
    masked_data_pkg::word_t shr;

    // Each level draws padding from its own slice
    assign fill_left  = i_pad[masked_data_pkg::XLEN-N -: N];
    assign fill_right = rotate ? lvl[k][N-1:0]   // Wrapped bits
                               : i_pad[2*N-2 -: N];

    assign shl = {lvl[k][masked_data_pkg::XLEN-1-N:0], fill_left};
    assign shr = {fill_right, lvl[k][masked_data_pkg::XLEN-1:N]};

    assign lvl[k+1] = !i_shamt[k] ? lvl[k]
                    : shift_left  ? shl
                    :               shr;
  end

  // Padding is identical in both shares and drops out on unmasking
  assign o_share = lvl[masked_data_pkg::SHAMT_W];

endmodule

`default_nettype wire

// ==== tb_masked_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_masked_alu;

  localparam int RESET_CYCLES   = 8;
  localparam int NUM_OPS        = 13;  // Opcodes in masked_op_e
  localparam int N_RAND         = 16;  // Random operations per opcode
  localparam int N_BURST        = 32;
  localparam int STIM_CYCLES    = RESET_CYCLES + 2 * NUM_OPS * N_RAND + N_BURST + 16;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

  typedef struct packed {
    masked_op_pkg::masked_op_e op;
    masked_data_pkg::word_t    value; // Unmasked result
  } expect_t;

  logic                      g_clk;
  logic                      g_resetn;
  logic                      i_valid;
  logic                      i_prng_update;
  masked_op_pkg::masked_op_e i_op;
  masked_data_pkg::word_t    i_rs1_s0, i_rs1_s1, i_rs2_s0, i_rs2_s1;
  wire                       o_ready;
  masked_data_pkg::word_t    o_rd_s0, o_rd_s1;

  expect_t                exp_q[$];
  masked_data_pkg::word_t last_s0;
  int                     cycle_count    = 0;
  int                     check_count    = 0;
  int                     value_errors   = 0;
  int                     reset_errors   = 0;
  int                     latency_errors = 0;
  int                     prng_errors    = 0;

  masked_alu_top i_masked_alu_top (
    .g_clk, .g_resetn, .i_valid, .i_prng_update, .i_op,
    .i_rs1_s0, .i_rs1_s1, .i_rs2_s0, .i_rs2_s1,
    .o_ready, .o_rd_s0, .o_rd_s1
  );

  always #4 g_clk = ~g_clk;

  // Reference result from unmasked operands
  function automatic masked_data_pkg::word_t model_result(
    input masked_op_pkg::masked_op_e op,
    input masked_data_pkg::word_t a0, a1, b0, b1
  );
    masked_data_pkg::word_t a_x, b_x, a_s, b_s;
    int unsigned            sh;
    a_x = a0 ^ a1;
    b_x = b0 ^ b1;
    a_s = a0 - a1;
    b_s = b0 - b1;
    sh  = {27'b0, b0[4:0]}; // Shift amount sits in rs2 share 0
    case (op)
      masked_op_pkg::OP_B_MASK:   return a0;
      masked_op_pkg::OP_B_REMASK: return a_x;
      masked_op_pkg::OP_B_NOT:    return ~a_x;
      masked_op_pkg::OP_B_XOR:    return a_x ^ b_x;
      masked_op_pkg::OP_B_AND:    return a_x & b_x;
      masked_op_pkg::OP_B_IOR:    return a_x | b_x;
      masked_op_pkg::OP_B_SRLI:   return a_x >> sh;
      masked_op_pkg::OP_B_SLLI:   return a_x << sh;
      masked_op_pkg::OP_B_RORI:   return (a_x >> sh) | (a_x << (masked_data_pkg::XLEN - sh));
      masked_op_pkg::OP_A_MASK:   return a0;
      masked_op_pkg::OP_A_REMASK: return a_s;
      masked_op_pkg::OP_A_ADD:    return a_s + b_s;
      masked_op_pkg::OP_A_SUB:    return a_s - b_s;
      default:                    return '0;
    endcase
  endfunction

  // Pop on each ready, push on each accepted operation
  always @(posedge g_clk) begin : check_results
    expect_t                head;
    masked_data_pkg::word_t actual;
    if (o_ready) begin
      if (exp_q.size() == 0) begin
        value_errors++;
        $display("Result returned with no operation outstanding");
      end else begin
        head   = exp_q.pop_front();
        actual = masked_op_pkg::is_arith_op(head.op) ? o_rd_s0 - o_rd_s1 : o_rd_s0 ^ o_rd_s1;
        check_count++;
        assert (actual == head.value) else begin
          value_errors++;
          $display("Fail %s: expected %h, actual %h", head.op.name(), head.value, actual);
        end
        last_s0 = o_rd_s0;
      end
    end
    if (g_resetn && i_valid) begin
      exp_q.push_back('{i_op, model_result(i_op, i_rs1_s0, i_rs1_s1, i_rs2_s0, i_rs2_s1)});
    end
  end

  assert property (@(posedge g_clk)
                   !g_resetn |=> !o_ready && o_rd_s0 == '0 && o_rd_s1 == '0)
  else begin
    reset_errors++;
    $display("o_ready or a result share was set during reset or right after it");
  end

  assert property (@(posedge g_clk) cycle_count > 0 |-> o_ready == $past(i_valid && g_resetn))
  else begin
    latency_errors++;
    $display("o_ready did not follow i_valid by exactly one cycle");
  end

  always @(posedge g_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycle_count, exp_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic send_op(input masked_op_pkg::masked_op_e op,
                         input masked_data_pkg::word_t r1s0, r1s1, r2s0, r2s1);
    @(posedge g_clk);
    i_valid       <= 1'b1;
    i_prng_update <= 1'b0;
    i_op          <= op;
    i_rs1_s0      <= r1s0;
    i_rs1_s1      <= r1s1;
    i_rs2_s0      <= r2s0;
    i_rs2_s1      <= r2s1;
  endtask

  task automatic idle_cycle;
    @(posedge g_clk);
    i_valid       <= 1'b0;
    i_prng_update <= 1'b0;
  endtask

  // Wait until every accepted operation has returned
  task automatic drain_results;
    do @(negedge g_clk); while (exp_q.size() != 0);
  endtask

  initial begin : stimulus
    masked_op_pkg::masked_op_e op;
    masked_data_pkg::word_t    value;
    masked_data_pkg::word_t    first_s0;
    int                        total;
    void'($urandom(32'h83f0));
    g_clk         = 1'b0;
    g_resetn      = 1'b0;
    i_valid       = 1'b1; // Requests during reset must be dropped
    i_prng_update = 1'b0;
    i_op          = masked_op_pkg::OP_B_MASK;
    i_rs1_s0      = '0;
    i_rs1_s1      = '0;
    i_rs2_s0      = '0;
    i_rs2_s1      = '0;
    repeat (RESET_CYCLES) @(posedge g_clk);
    g_resetn <= 1'b1;
    i_valid  <= 1'b0;
    repeat (2) idle_cycle();

    // Every opcode with random shares, one idle cycle between ops
    op = op.first();
    repeat (NUM_OPS) begin
      repeat (N_RAND) begin
        send_op(op, $urandom(), $urandom(), $urandom(), $urandom());
        idle_cycle();
      end
      op = op.next();
    end
    drain_results();

    // Back-to-back burst, mixed opcodes
    repeat (N_BURST) begin
      op = op.first();
      repeat ($urandom_range(NUM_OPS - 1)) op = op.next();
      send_op(op, $urandom(), $urandom(), $urandom(), $urandom());
    end
    idle_cycle();
    drain_results();

    // Same mask twice around a PRNG update
    value = $urandom();
    send_op(masked_op_pkg::OP_B_MASK, value, $urandom(), $urandom(), $urandom());
    idle_cycle();
    drain_results();
    first_s0 = last_s0;
    @(posedge g_clk);
    i_prng_update <= 1'b1;
    idle_cycle();
    send_op(masked_op_pkg::OP_B_MASK, value, $urandom(), $urandom(), $urandom());
    idle_cycle();
    drain_results();
    assert (last_s0 != first_s0) else begin
      prng_errors++;
      $display("Share 0 did not change after a PRNG update, both were %h", last_s0);
    end

    repeat (4) idle_cycle();
    total = value_errors + reset_errors + latency_errors + prng_errors;
    $display("Checks %0d, value errors %0d, reset errors %0d, handshake errors %0d, PRNG errors %0d",
             check_count, value_errors, reset_errors, latency_errors, prng_errors);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
